// ==== Makefile ====
# Verilator flow for the potion puzzle testbench

VERILATOR ?= verilator
TOP       ?= tbPotion
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/potionPkg.sv ====
package potionPkg;

    ////////////////////
    // Game sizes
    ////////////////////
    localparam int NumTubes    = 7;
    localparam int TubeDepth   = 4;
    localparam int CursorSlots = 8;             // Last slot is not a tube
    localparam int RowSlots    = CursorSlots / 2;

    typedef logic [2:0] colourT;                // 0 blank, 1 to 6 liquid
    typedef logic [2:0] levelT;                 // Units filled, 0 to 4
    typedef logic [2:0] slotT;
    typedef colourT [NumTubes-1:0][TubeDepth-1:0] rackT;  // Unit 0 at the bottom
    typedef logic [9:0] scoreT;
    typedef logic [6:0] pctT;

    localparam slotT NoTube = 3'd7;             // Nothing confirmed

    // Listed from tube 6 down to tube 0, each tube from its top unit down
    // Every pair of mixed tubes swaps its top units, tube 6 is the spare
    localparam rackT StartLayout = '{
        '{3'd0, 3'd0, 3'd0, 3'd0},
        '{3'd5, 3'd6, 3'd6, 3'd6},
        '{3'd6, 3'd5, 3'd5, 3'd5},
        '{3'd3, 3'd4, 3'd4, 3'd4},
        '{3'd4, 3'd3, 3'd3, 3'd3},
        '{3'd1, 3'd2, 3'd2, 3'd2},
        '{3'd2, 3'd1, 3'd1, 3'd1}
    };

    ////////////////////
    // Timing and score
    ////////////////////
    localparam int RoundCycles    = 3000;
    localparam int TimerBits      = $clog2(RoundCycles + 1);
    localparam int FullPct        = 100;
    localparam int FinishedPoints = 100;
    localparam int PenaltyPerPct  = 5;
    localparam int WinHoldCycles  = 200;
    localparam int HoldBits       = $clog2(WinHoldCycles);

    typedef logic [TimerBits-1:0] timerT;
    typedef logic [HoldBits-1:0] holdT;

endpackage

// ==== cursor/cursorControl.sv ====
`timescale 1ns/1ps

module cursorControl (
    input  logic                               single_pulse_clk,
    input  logic                               rst,
    input  logic                               start,
    input  logic                               playing,
    input  logic                               btnL,
    input  logic                               btnR,
    input  logic                               btnU,
    input  logic                               btnD,
    input  logic                               btnC,
    output logic [potionPkg::CursorSlots-1:0]  selected,
    output logic [potionPkg::CursorSlots-1:0]  confirmed,
    output logic                               pourReq,
    output potionPkg::slotT                    pourSrc,
    output potionPkg::slotT                    pourDst,
    output logic                               quit
);

    potionPkg::slotT                   cursor;        // Slot under the cursor
    potionPkg::slotT                   confirmSlot;   // NoTube when empty
    potionPkg::slotT                   cursorNext;
    logic                              haveConfirm;
    logic                              onConfirm;
    logic                              onNoTube;

    assign haveConfirm = (confirmSlot != potionPkg::NoTube);
    assign onConfirm   = haveConfirm && (cursor == confirmSlot);
    assign onNoTube    = (cursor == potionPkg::NoTube);

    ////////////////////
    // Centre button
    ////////////////////
    // Quit only from the spare slot with no tube held
    assign quit    = playing && btnC && !haveConfirm && onNoTube;
    assign pourReq = playing && btnC && haveConfirm && !onConfirm && !onNoTube;
    assign pourSrc = confirmSlot;
    assign pourDst = cursor;

    ////////////////////
    // Grid movement
    ////////////////////
    always_comb begin
        cursorNext = cursor;
        if (btnL) begin
            if (cursor != '0 && cursor != potionPkg::slotT'(potionPkg::RowSlots)) begin
                cursorNext = cursor - 3'd1;
            end
        end else if (btnR) begin
            if (cursor != potionPkg::slotT'(potionPkg::RowSlots - 1) &&
                cursor != potionPkg::slotT'(potionPkg::CursorSlots - 1)) begin
                cursorNext = cursor + 3'd1;
            end
        end else if (btnU) begin
            if (cursor >= potionPkg::slotT'(potionPkg::RowSlots)) begin
                cursorNext = cursor - potionPkg::slotT'(potionPkg::RowSlots);  // Up a row
            end
        end else if (btnD) begin
            if (cursor < potionPkg::slotT'(potionPkg::RowSlots)) begin
                cursorNext = cursor + potionPkg::slotT'(potionPkg::RowSlots);
            end
        end
    end

    always_ff @(posedge single_pulse_clk) begin
        if (rst || start) begin
            cursor      <= '0;
            confirmSlot <= potionPkg::NoTube;
        end else if (playing) begin
            cursor <= cursorNext;
            if (btnC) begin
                // A held tube is dropped by cancel or pour, the spare slot holds nothing
                if (haveConfirm || onNoTube) begin
                    confirmSlot <= potionPkg::NoTube;
                end else begin
                    confirmSlot <= cursor;
                end
            end
        end
    end

    assign selected  = {{(potionPkg::CursorSlots - 1){1'b0}}, 1'b1} << cursor;
    assign confirmed = haveConfirm ?
                       ({{(potionPkg::CursorSlots - 1){1'b0}}, 1'b1} << confirmSlot) : '0;

endmodule

// ==== hdl/potionTop.sv ====
`timescale 1ns/1ps

module potionTop (
    input  logic                               single_pulse_clk,
    input  logic                               rst,
    input  logic                               start,
    input  logic                               btnL,
    input  logic                               btnR,
    input  logic                               btnU,
    input  logic                               btnD,
    input  logic                               btnC,
    output potionPkg::rackT                    tubes,
    output logic [potionPkg::CursorSlots-1:0]  selected,
    output logic [potionPkg::CursorSlots-1:0]  confirmed,
    output potionPkg::pctT                     timeLeftPct,
    output potionPkg::scoreT                   score,
    output logic                               won,
    output logic                               ended
);

    logic            playing;        // Round in progress
    logic            pourReq;
    potionPkg::slotT pourSrc;
    potionPkg::slotT pourDst;
    logic            quit;
    logic [2:0]      finishedCount;
    logic            expired;

    ////////////////////
    // Player input
    ////////////////////
    cursorControl cursor (
        .single_pulse_clk (single_pulse_clk),
        .rst              (rst),
        .start            (start),
        .playing          (playing),
        .btnL             (btnL),
        .btnR             (btnR),
        .btnU             (btnU),
        .btnD             (btnD),
        .btnC             (btnC),
        .selected         (selected),
        .confirmed        (confirmed),
        .pourReq          (pourReq),
        .pourSrc          (pourSrc),
        .pourDst          (pourDst),
        .quit             (quit)
    );

    ////////////////////
    // Board and clock
    ////////////////////
    tubeRack rack (
        .single_pulse_clk (single_pulse_clk),
        .rst              (rst),
        .start            (start),
        .pourReq          (pourReq),
        .pourSrc          (pourSrc),
        .pourDst          (pourDst),
        .tubes            (tubes),
        .finishedCount    (finishedCount)
    );

    roundTimer timer (
        .single_pulse_clk (single_pulse_clk),
        .rst              (rst),
        .start            (start),
        .playing          (playing),
        .timeLeftPct      (timeLeftPct),
        .expired          (expired)
    );

    // Round state lives with the score
    scoreCombine scorer (
        .single_pulse_clk (single_pulse_clk),
        .rst              (rst),
        .start            (start),
        .finishedCount    (finishedCount),
        .timeLeftPct      (timeLeftPct),
        .expired          (expired),
        .quit             (quit),
        .playing          (playing),
        .score            (score),
        .won              (won),
        .ended            (ended)
    );

endmodule

// ==== hdl/roundTimer.sv ====
`timescale 1ns/1ps

module roundTimer (
    input  logic           single_pulse_clk,
    input  logic           rst,
    input  logic           start,
    input  logic           playing,
    output potionPkg::pctT timeLeftPct,
    output logic           expired
);

    potionPkg::timerT remaining;     // Cycles left in the round
    logic [31:0]      scaled;

    ////////////////////
    // Countdown
    ////////////////////
    always_ff @(posedge single_pulse_clk) begin
        if (rst || start) begin
            remaining <= potionPkg::timerT'(potionPkg::RoundCycles);
        end else if (playing && remaining != '0) begin
            remaining <= remaining - potionPkg::timerT'(1);
        end
    end

    // Last cycle of play, the count then settles at zero
    assign expired = playing && (remaining == potionPkg::timerT'(1));

    // Percentage rounds down
    assign scaled      = 32'(remaining) * 32'(potionPkg::FullPct);
    assign timeLeftPct = potionPkg::pctT'(scaled / 32'(potionPkg::RoundCycles));

endmodule

// ==== hdl/scoreCombine.sv ====
`timescale 1ns/1ps

module scoreCombine (
    input  logic             single_pulse_clk,
    input  logic             rst,
    input  logic             start,
    input  logic [2:0]       finishedCount,
    input  potionPkg::pctT   timeLeftPct,
    input  logic             expired,
    input  logic             quit,
    output logic             playing,
    output potionPkg::scoreT score,
    output logic             won,
    output logic             ended
);

    potionPkg::holdT  holdCount;     // Cycles spent solved
    potionPkg::scoreT points;
    potionPkg::scoreT penalty;
    potionPkg::scoreT scoreNext;
    logic             solved;

    assign solved  = (finishedCount == 3'(potionPkg::NumTubes));
    assign points  = potionPkg::scoreT'(finishedCount) *
                     potionPkg::scoreT'(potionPkg::FinishedPoints);
    // Penalty grows with the share of time used
    assign penalty = potionPkg::scoreT'(potionPkg::pctT'(potionPkg::FullPct) - timeLeftPct) *
                     potionPkg::scoreT'(potionPkg::PenaltyPerPct);
    assign scoreNext = (points > penalty) ? points - penalty : '0;   // Floor at zero

    always_ff @(posedge single_pulse_clk) begin
        if (rst || start) begin
            playing   <= !rst;              // A new round begins on start
            won       <= 1'b0;
            ended     <= 1'b0;
            score     <= '0;
            holdCount <= '0;
        end else if (playing) begin
            score <= scoreNext;
            if (expired || quit) begin
                ended   <= 1'b1;
                playing <= 1'b0;
            end
            if (!solved) begin
                holdCount <= '0;
            end else if (holdCount == potionPkg::holdT'(potionPkg::WinHoldCycles - 1)) begin
                won     <= 1'b1;
                playing <= 1'b0;
            end else begin
                holdCount <= holdCount + potionPkg::holdT'(1);
            end
        end
    end

endmodule

// ==== sim.f ====
common/potionPkg.sv
cursor/cursorControl.sv
tubes/tubeRack.sv
hdl/roundTimer.sv
hdl/scoreCombine.sv
hdl/potionTop.sv
sim/potionProperties_properties.sv
sim/tbPotion.sv

// ==== sim/potionProperties_properties.sv ====
`timescale 1ns/1ps

module potionProperties (
    input logic                              single_pulse_clk,
    input logic                              rst,
    input logic                              start,
    input logic                              btnL,
    input logic                              btnR,
    input logic                              btnU,
    input logic                              btnD,
    input logic                              btnC,
    input potionPkg::rackT                   tubes,
    input logic [potionPkg::CursorSlots-1:0] selected,
    input logic [potionPkg::CursorSlots-1:0] confirmed,
    input potionPkg::pctT                    timeLeftPct,
    input potionPkg::scoreT                  score,
    input logic                              won,
    input logic                              ended,
    input logic                              playing
);

    int unsigned failures = 0;      // Read by the testbench
    int unsigned playCount;         // Play cycles since start
    logic        solvedNow;
    logic        lonePress;

    ////////////////////
    // Reference rules
    ////////////////////
    function automatic logic [7:0] moveSel(logic [7:0] sel, logic l, logic r, logic u, logic d);
        int idx;
        idx = 0;
        for (int i = 0; i < 8; i++) begin
            if (sel[i]) idx = i;
        end
        if (l && (idx % 4) != 0) idx = idx - 1;
        else if (r && (idx % 4) != 3) idx = idx + 1;
        else if (u && idx >= 4) idx = idx - 4;   // Top row is 0 to 3
        else if (d && idx < 4) idx = idx + 4;
        return 8'd1 << idx;
    endfunction

    function automatic int countFinished(potionPkg::rackT r);
        int n;
        n = 0;
        for (int t = 0; t < potionPkg::NumTubes; t++) begin
            if (r[t][1] == r[t][0] && r[t][2] == r[t][0] && r[t][3] == r[t][0]) n++;
        end
        return n;
    endfunction

    function automatic potionPkg::scoreT scoreOf(int fin, potionPkg::pctT pct);
        int pts;
        int pen;
        pts = fin * potionPkg::FinishedPoints;
        pen = (100 - int'(pct)) * potionPkg::PenaltyPerPct;
        return (pts > pen) ? potionPkg::scoreT'(pts - pen) : '0;
    endfunction

    // Four of each colour and no liquid resting on a blank
    function automatic logic rackSane(potionPkg::rackT r);
        int cnt [7];
        logic ok;
        ok = 1'b1;
        for (int c = 0; c < 7; c++) cnt[c] = 0;
        for (int t = 0; t < potionPkg::NumTubes; t++) begin
            for (int u = 0; u < potionPkg::TubeDepth; u++) begin
                cnt[r[t][u]]++;
                if (u > 0 && r[t][u] != '0 && r[t][u-1] == '0) ok = 1'b0;
            end
        end
        for (int c = 1; c < 7; c++) begin
            if (cnt[c] != 4) ok = 1'b0;
        end
        return ok;
    endfunction

    assign solvedNow = (countFinished(tubes) == potionPkg::NumTubes);
    assign lonePress = $onehot({btnL, btnR, btnU, btnD});

    always @(posedge single_pulse_clk) begin
        if (rst || start) playCount <= 0;
        else if (playing) playCount <= playCount + 1;
    end

    ////////////////////
    // Checks
    ////////////////////
    aResetState: assert property (@(posedge single_pulse_clk)
        $fell(rst) |-> selected == 8'd1 && confirmed == '0 && !won && !ended && score == '0)
        else begin $error("MISMATCH at %0t: state after reset", $time); failures++; end

    aStartLoad: assert property (@(posedge single_pulse_clk) disable iff (rst)
        start |=> tubes == potionPkg::StartLayout && timeLeftPct == 7'd100)
        else begin $error("MISMATCH at %0t: layout or timer after start", $time); failures++; end

    aOneHot: assert property (@(posedge single_pulse_clk) disable iff (rst) $onehot(selected))
        else begin $error("MISMATCH at %0t: selected not one-hot", $time); failures++; end

    aMove: assert property (@(posedge single_pulse_clk) disable iff (rst)
        playing && !start && lonePress && !btnC |=>
            selected == moveSel($past(selected), $past(btnL), $past(btnR), $past(btnU), $past(btnD)))
        else begin $error("MISMATCH at %0t: cursor move", $time); failures++; end

    aConfirm: assert property (@(posedge single_pulse_clk) disable iff (rst)
        playing && !start && btnC && confirmed == '0 && !selected[7] |=> confirmed == $past(selected))
        else begin $error("MISMATCH at %0t: confirm", $time); failures++; end

    // Cancel and pour both drop the held tube
    aRelease: assert property (@(posedge single_pulse_clk) disable iff (rst)
        playing && !start && btnC && confirmed != '0 |=> confirmed == '0)
        else begin $error("MISMATCH at %0t: confirm not cleared", $time); failures++; end

    aRackSane: assert property (@(posedge single_pulse_clk) disable iff (rst)
        tubes != '0 |-> rackSane(tubes))
        else begin $error("MISMATCH at %0t: colours lost or gap in a tube", $time); failures++; end

    aScore: assert property (@(posedge single_pulse_clk) disable iff (rst)
        playing && !start |=> score == scoreOf(countFinished($past(tubes)), $past(timeLeftPct)))
        else begin $error("MISMATCH at %0t: score", $time); failures++; end

    // won is sticky within a round, so a rise exactly here rules out an early one
    aWinHold: assert property (@(posedge single_pulse_clk) disable iff (rst || start)
        $rose(solvedNow) && playing |-> ##(potionPkg::WinHoldCycles) (won && !$past(won)))
        else begin $error("MISMATCH at %0t: win hold", $time); failures++; end

    aTimerFrozen: assert property (@(posedge single_pulse_clk) disable iff (rst)
        won && !start |=> $stable(timeLeftPct))
        else begin $error("MISMATCH at %0t: timer runs after win", $time); failures++; end

    aTimerDown: assert property (@(posedge single_pulse_clk) disable iff (rst)
        !start |=> timeLeftPct <= $past(timeLeftPct))
        else begin $error("MISMATCH at %0t: time left increased", $time); failures++; end

    aTimeout: assert property (@(posedge single_pulse_clk) disable iff (rst)
        $rose(ended) && !$past(btnC) |-> playCount == potionPkg::RoundCycles)
        else begin $error("MISMATCH at %0t: round length", $time); failures++; end

    aQuit: assert property (@(posedge single_pulse_clk) disable iff (rst)
        playing && !start && btnC && confirmed == '0 && selected[7] |=> ended && !won)
        else begin $error("MISMATCH at %0t: quit", $time); failures++; end

endmodule

bind potionTop potionProperties props (.*);

// ==== sim/tbPotion.sv ====
`timescale 1ns/1ps

module tbPotion;

    localparam int WatchdogCycles = 3 * potionPkg::RoundCycles + 2000;

    logic            single_pulse_clk;
    logic            rst;
    logic            start;
    logic            btnL, btnR, btnU, btnD, btnC;
    potionPkg::rackT tubes;
    logic [7:0]      selected;
    logic [7:0]      confirmed;
    potionPkg::pctT  timeLeftPct;
    potionPkg::scoreT score;
    logic            won;
    logic            ended;

    int              cur;            // Cursor slot as the testbench expects it
    potionPkg::rackT expRack;

    potionTop uut (.*);

    initial single_pulse_clk = 1'b0;
    always #2 single_pulse_clk = ~single_pulse_clk;

    ////////////////////
    // Stimulus helpers
    ////////////////////
    // 0 left, 1 right, 2 up, 3 down, 4 centre
    task automatic pressButton(int which);
        @(posedge single_pulse_clk);
        #1;
        {btnL, btnR, btnU, btnD, btnC} = 5'b10000 >> which;
        @(posedge single_pulse_clk);
        #1;
        {btnL, btnR, btnU, btnD, btnC} = '0;
        if (which == 0 && cur % 4 != 0) cur--;
        else if (which == 1 && cur % 4 != 3) cur++;
        else if (which == 2 && cur >= 4) cur -= 4;
        else if (which == 3 && cur < 4) cur += 4;
    endtask

    task automatic startRound();
        @(posedge single_pulse_clk);
        #1 start = 1'b1;
        @(posedge single_pulse_clk);
        #1 start = 1'b0;
        cur     = 0;
        expRack = potionPkg::StartLayout;
    endtask

    task automatic moveTo(int target);
        while (cur != target) begin
            if (target / 4 > cur / 4) pressButton(3);
            else if (target / 4 < cur / 4) pressButton(2);
            else if (target > cur) pressButton(1);
            else pressButton(0);
        end
    endtask

    task automatic wander(int n);
        repeat (n) pressButton($urandom % 4);
    endtask

    // Pour rule applied unit by unit
    function automatic potionPkg::rackT pourModel(potionPkg::rackT r, int s, int d);
        int sl;
        int dl;
        sl = 0;
        dl = 0;
        for (int u = 0; u < 4; u++) begin
            if (r[s][u] != '0) sl++;
            if (r[d][u] != '0) dl++;
        end
        while (sl > 0 && dl < 4 && (dl == 0 || r[d][dl-1] == r[s][sl-1])) begin
            r[d][dl]   = r[s][sl-1];
            r[s][sl-1] = '0;
            sl--;
            dl++;
        end
        return r;
    endfunction

    task automatic pourBetween(int s, int d);
        moveTo(s);
        pressButton(4);
        moveTo(d);
        pressButton(4);
        expRack = pourModel(expRack, s, d);
        if (tubes != expRack) begin
            $display("MISMATCH at %0t: tubes after pour %0d to %0d", $time, s, d);
            $display("Test failed");
            $fatal(1, "tube contents differ");
        end
    endtask

    // Any assertion failure ends the run
    always @(uut.props.failures) begin
        if (uut.props.failures != 0) begin
            $display("Test failed");
            $fatal(1, "assertion failed");
        end
    end

    initial begin
        #(WatchdogCycles * 4);
        $display("Watchdog expired before the test sequence finished");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'h74ad_511f));
        rst   = 1'b1;
        start = 1'b0;
        {btnL, btnR, btnU, btnD, btnC} = '0;
        cur   = 0;
        repeat (2) @(posedge single_pulse_clk);
        #1 rst = 1'b0;
        repeat (2) @(posedge single_pulse_clk);

        // Round one, solved by swapping tops through the spare tube
        startRound();
        wander(6);
        moveTo(2);
        pressButton(4);              // Confirm then cancel
        pressButton(4);
        for (int p = 0; p < 3; p++) begin
            pourBetween(2 * p, 6);
            pourBetween(2 * p + 1, 2 * p);
            pourBetween(6, 2 * p + 1);
        end
        wait (won);
        repeat (5) @(posedge single_pulse_clk);

        // Round two runs out of time
        startRound();
        wander(20);
        wait (ended);
        repeat (3) @(posedge single_pulse_clk);

        // Round three quits from the spare slot
        startRound();
        pressButton(0);              // Edge presses that leave the cursor in place
        pressButton(2);
        moveTo(7);
        pressButton(1);
        pressButton(3);
        pressButton(4);
        repeat (3) @(posedge single_pulse_clk);

        if (uut.props.failures == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

// ==== tubes/tubeRack.sv ====
`timescale 1ns/1ps

module tubeRack (
    input  logic            single_pulse_clk,
    input  logic            rst,
    input  logic            start,
    input  logic            pourReq,
    input  potionPkg::slotT pourSrc,
    input  potionPkg::slotT pourDst,
    output potionPkg::rackT tubes,
    output logic [2:0]      finishedCount
);

    potionPkg::levelT levels [potionPkg::NumTubes];   // Units in each tube

    // Working copies for the pour engine
    potionPkg::colourT [potionPkg::TubeDepth-1:0] srcTube;
    potionPkg::colourT [potionPkg::TubeDepth-1:0] dstTube;
    potionPkg::levelT                             srcLvl;
    potionPkg::levelT                             dstLvl;
    logic [1:0]                                   srcTop;
    logic [1:0]                                   dstTop;

    // Liquid never has a gap under it, so a tube's level is its non-blank count
    function automatic potionPkg::levelT fillLevel(
        input potionPkg::colourT [potionPkg::TubeDepth-1:0] tube
    );
        potionPkg::levelT n;
        n = '0;
        for (int u = 0; u < potionPkg::TubeDepth; u++) begin
            if (tube[u] != '0) begin
                n = n + 3'd1;
            end
        end
        return n;
    endfunction

    ////////////////////
    // Pour engine
    ////////////////////
    // Up to four units move in one cycle, one per unrolled step
    always_comb begin
        srcTube = tubes[pourSrc];
        dstTube = tubes[pourDst];
        srcLvl  = levels[pourSrc];
        dstLvl  = levels[pourDst];
        srcTop  = '0;
        dstTop  = '0;
        for (int step = 0; step < potionPkg::TubeDepth; step++) begin
            srcTop = srcLvl[1:0] - 2'd1;     // Level 4 wraps to unit 3
            dstTop = dstLvl[1:0] - 2'd1;
            if (srcLvl != '0 &&
                dstLvl != potionPkg::levelT'(potionPkg::TubeDepth) &&
                (dstLvl == '0 || dstTube[dstTop] == srcTube[srcTop])) begin
                dstTube[dstLvl[1:0]] = srcTube[srcTop];
                srcTube[srcTop]      = '0;
                srcLvl               = srcLvl - 3'd1;
                dstLvl               = dstLvl + 3'd1;
            end
        end
    end

    ////////////////////
    // Tube storage
    ////////////////////
    always_ff @(posedge single_pulse_clk) begin
        if (rst) begin
            tubes <= '0;                     // All blank
            for (int t = 0; t < potionPkg::NumTubes; t++) begin
                levels[t] <= '0;
            end
        end else if (start) begin
            tubes <= potionPkg::StartLayout;
            for (int t = 0; t < potionPkg::NumTubes; t++) begin
                levels[t] <= fillLevel(potionPkg::StartLayout[t]);
            end
        end else if (pourReq) begin
            // Source and destination always differ
            tubes[pourSrc]  <= srcTube;
            tubes[pourDst]  <= dstTube;
            levels[pourSrc] <= srcLvl;
            levels[pourDst] <= dstLvl;
        end
    end

    ////////////////////
    // Finished tubes
    ////////////////////
    // A tube of one colour throughout is finished, an empty one too
    always_comb begin
        logic uniform;
        uniform       = 1'b0;
        finishedCount = '0;
        for (int t = 0; t < potionPkg::NumTubes; t++) begin
            uniform = 1'b1;
            for (int u = 1; u < potionPkg::TubeDepth; u++) begin
                if (tubes[t][u] != tubes[t][0]) begin
                    uniform = 1'b0;
                end
            end
            if (uniform) begin
                finishedCount = finishedCount + 3'd1;
            end
        end
    end

endmodule
